//--- Makefile
# Verilator build and run for the fractal renderer testbench.

VERILATOR ?= verilator
TOP       ?= fractal_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/coord_converter.sv
module coord_converter
   import fx_math_pkg::*, job_pkg::*;
#(
   parameter fx_t X_MIN = fx_t'(-8192),
   parameter fx_t Y_MIN = fx_t'(-5120),
   parameter fx_t STEP  = fx_t'(768)
) (
   input  logic   clk,
   input  logic   n_rst,
   input  logic   convert_start,
   input  pixel_t cur_pixel,
   output logic   convert_done,
   output point_t point
);

   logic [1:0] done_sr;
   logic       start_rise;
   pixel_t     pix_q;
   fx_t        x_off;
   fx_t        y_off;

   // First cycle of a request, the shift register is still empty.
   assign start_rise = convert_start && !done_sr[0];

   always_ff @(posedge clk, negedge n_rst) begin
      if (!n_rst) begin
         done_sr <= '0;
      end else if (!convert_start) begin
         done_sr <= '0;
      end else begin
         done_sr <= {done_sr[0], 1'b1};
      end
   end

   assign convert_done = done_sr[1];

   // Integer coordinate times a fixed-point step needs no shift.
   assign x_off = fx_t'(pix_q.x) * STEP;
   assign y_off = fx_t'(pix_q.y) * STEP;

   always_ff @(posedge clk) begin
      if (start_rise) begin
         pix_q <= cur_pixel;
      end
      if (done_sr == 2'b01) begin
         point.pix <= pix_q;
         point.cr  <= X_MIN + x_off;
         point.ci  <= Y_MIN + y_off;
      end
   end

endmodule

//--- hw/escape_calc.sv
module escape_calc
   import fx_math_pkg::*, job_pkg::*;
#(
   parameter int MAX_ITER = 32
) (
   input  logic    clk,
   input  logic    n_rst,
   input  logic    calc_start,
   input  point_t  point,
   output logic    calc_done,
   output result_t result
);

   calc_state_t state;
   pixel_t      pix;
   fx_t         cr;
   fx_t         ci;
   fx_t         zr;
   fx_t         zi;
   iter_t       count;
   fx_wide_t    zr2;
   fx_wide_t    zi2;
   fx_wide_t    zrzi;
   fx_wide_t    mag2;
   logic        escaped;
   logic        at_limit;
   logic        stop;

   // Products of the current z, kept wide for the escape test.
   assign zr2  = fx_mul(zr, zr);
   assign zi2  = fx_mul(zi, zi);
   assign zrzi = fx_mul(zr, zi);
   assign mag2 = zr2 + zi2;

   assign escaped  = mag2 > fx_wide_t'(FX_ESCAPE);
   assign at_limit = count == iter_t'(MAX_ITER);
   assign stop     = escaped || at_limit;

   always_ff @(posedge clk, negedge n_rst) begin
      if (!n_rst) begin
         state <= C_IDLE;
      end else begin
         case (state)
            C_IDLE: begin
               if (calc_start) begin
                  state <= C_RUN;
               end
            end
            C_RUN: begin
               if (stop) begin
                  state <= C_DONE;
               end
            end
            // Hold the result until the unit drops its request.
            C_DONE: begin
               if (!calc_start) begin
                  state <= C_IDLE;
               end
            end
            default: begin
               state <= C_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == C_IDLE && calc_start) begin
         pix   <= point.pix;
         cr    <= point.cr;
         ci    <= point.ci;
         zr    <= '0;
         zi    <= '0;
         count <= '0;
      end else if (state == C_RUN && !stop) begin
         // z = z^2 + c, wrapping at 16 bits.
         zr    <= fx_t'(zr2) - fx_t'(zi2) + cr;
         zi    <= fx_t'(zrzi) + fx_t'(zrzi) + ci;
         count <= count + 1'b1;
      end
   end

   assign calc_done   = state == C_DONE;
   assign result.pix  = pix;
   assign result.iter = count;

endmodule

//--- hw/fractal_top.sv
module fractal_top
   import fx_math_pkg::*, job_pkg::*;
#(
   parameter int  WIDTH    = 16,
   parameter int  HEIGHT   = 12,
   parameter int  MAX_ITER = 32,
   parameter fx_t X_MIN    = fx_t'(-8192),
   parameter fx_t Y_MIN    = fx_t'(-5120),
   parameter fx_t STEP     = fx_t'(768)
) (
   input  logic    clk,
   input  logic    n_rst,
   input  logic    frame_req,
   input  logic    mem_ack,
   output logic    frame_ack,
   output logic    mem_req,
   output mem_wr_t mem_wr
);

   logic    job_ready;
   logic    job_start;
   logic    convert_start;
   logic    convert_done;
   logic    calc_start;
   logic    calc_done;
   logic    job_done;
   logic    mc_done;
   pixel_t  cur_pixel;
   point_t  point;
   result_t result;

   work_dispatcher #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) dispatch_i (
      .clk, .n_rst, .frame_req, .job_ready,
      .frame_ack, .job_start, .cur_pixel
   );

   work_control_unit wcu_i (
      .clk, .n_rst, .job_start, .convert_done, .calc_done, .mc_done,
      .job_ready, .convert_start, .calc_start, .job_done
   );

   coord_converter #(.X_MIN(X_MIN), .Y_MIN(Y_MIN), .STEP(STEP)) convert_i (
      .clk, .n_rst, .convert_start, .cur_pixel,
      .convert_done, .point
   );

   escape_calc #(.MAX_ITER(MAX_ITER)) calc_i (
      .clk, .n_rst, .calc_start, .point,
      .calc_done, .result
   );

   result_writer #(.WIDTH(WIDTH)) writer_i (
      .clk, .n_rst, .job_done, .result, .mem_ack,
      .mc_done, .mem_req, .mem_wr
   );

endmodule

//--- hw/fx_math_pkg.sv
package fx_math_pkg;

   // Word width and fraction bits of the signed Q4.12 format.
   localparam int FX_W    = 16;
   localparam int FX_FRAC = 12;

   // Plain fixed-point value.
   typedef logic signed [FX_W-1:0] fx_t;

   // Full-width product, before the fraction shift.
   typedef logic signed [2*FX_W-1:0] fx_wide_t;

   // Escape bound on |z|^2, 4.0 in fx_t units.
   localparam fx_t FX_ESCAPE = fx_t'(4 << FX_FRAC);

   // Signed multiply, scaled back to the fx_t fraction position.
   // The result stays wide so that large squares do not wrap.
   function automatic fx_wide_t fx_mul(fx_t a, fx_t b);
      fx_wide_t prod;
      prod = fx_wide_t'(a) * fx_wide_t'(b);
      return prod >>> FX_FRAC;
   endfunction

endpackage

//--- hw/job_pkg.sv
package job_pkg;
   import fx_math_pkg::*;

   // Pixel coordinate and iteration count.
   typedef logic [7:0] coord_t;
   typedef logic [7:0] iter_t;

   // Word address on the result memory.
   typedef logic [15:0] addr_t;

   typedef struct packed {
      coord_t y;
      coord_t x;
   } pixel_t;

   // Pixel together with its point in the complex plane.
   typedef struct packed {
      pixel_t pix;
      fx_t    cr;
      fx_t    ci;
   } point_t;

   typedef struct packed {
      pixel_t pix;
      iter_t  iter;
   } result_t;

   typedef struct packed {
      addr_t addr;
      iter_t data;
   } mem_wr_t;

   typedef enum logic [2:0] {IDLE, ASK_WAIT, CONVERT, CALC1, CALC2, WRITE_WAIT} wcu_state_t;
   typedef enum logic [1:0] {C_IDLE, C_RUN, C_DONE} calc_state_t;
   typedef enum logic [1:0] {W_IDLE, W_REQ, W_RELEASE, W_DONE} wr_state_t;

endpackage

//--- hw/result_writer.sv
module result_writer
   import job_pkg::*;
#(
   parameter int WIDTH = 16
) (
   input  logic    clk,
   input  logic    n_rst,
   input  logic    job_done,
   input  result_t result,
   input  logic    mem_ack,
   output logic    mc_done,
   output logic    mem_req,
   output mem_wr_t mem_wr
);

   wr_state_t state;

   always_ff @(posedge clk, negedge n_rst) begin
      if (!n_rst) begin
         state <= W_IDLE;
      end else begin
         case (state)
            W_IDLE: begin
               if (job_done) begin
                  state <= W_REQ;
               end
            end
            W_REQ: begin
               if (mem_ack) begin
                  state <= W_RELEASE;
               end
            end
            // Request is down, wait for the memory to drop its ack.
            W_RELEASE: begin
               if (!mem_ack) begin
                  state <= W_DONE;
               end
            end
            W_DONE: begin
               if (!job_done) begin
                  state <= W_IDLE;
               end
            end
            default: begin
               state <= W_IDLE;
            end
         endcase
      end
   end

   // Raster address y*WIDTH+x, loaded before the request goes up.
   always_ff @(posedge clk) begin
      if (state == W_IDLE && job_done) begin
         mem_wr.addr <= addr_t'(result.pix.y) * addr_t'(WIDTH) + addr_t'(result.pix.x);
         mem_wr.data <= result.iter;
      end
   end

   assign mem_req = state == W_REQ;
   assign mc_done = state == W_DONE;

endmodule

//--- hw/work_control_unit.sv
module work_control_unit
   import job_pkg::*;
(
   input  logic clk,
   input  logic n_rst,
   input  logic job_start,
   input  logic convert_done,
   input  logic calc_done,
   input  logic mc_done,
   output logic job_ready,
   output logic convert_start,
   output logic calc_start,
   output logic job_done
);

   wcu_state_t state;
   wcu_state_t next_state;

   always_ff @(posedge clk, negedge n_rst) begin
      if (!n_rst) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state    = state;
      job_ready     = 1'b0;
      convert_start = 1'b0;
      calc_start    = 1'b0;
      job_done      = 1'b0;

      case (state)
         IDLE: begin
            next_state = ASK_WAIT;
         end

         // Wait for the dispatcher to hand over a pixel.
         ASK_WAIT: begin
            job_ready = 1'b1;
            if (job_start) begin
               next_state = CONVERT;
            end
         end

         CONVERT: begin
            convert_start = 1'b1;
            if (convert_done) begin
               next_state = CALC1;
            end
         end

         // Single cycle that raises calc_start before done is looked at.
         CALC1: begin
            calc_start = 1'b1;
            next_state = CALC2;
         end

         CALC2: begin
            calc_start = 1'b1;
            if (calc_done) begin
               next_state = WRITE_WAIT;
            end
         end

         // calc_start stays up so the result holds during the write.
         WRITE_WAIT: begin
            calc_start = 1'b1;
            job_done   = 1'b1;
            if (mc_done) begin
               next_state = ASK_WAIT;
            end
         end

         default: begin
            next_state = IDLE;
         end
      endcase
   end

endmodule

//--- hw/work_dispatcher.sv
module work_dispatcher
   import job_pkg::*;
#(
   parameter int WIDTH  = 16,
   parameter int HEIGHT = 12
) (
   input  logic   clk,
   input  logic   n_rst,
   input  logic   frame_req,
   input  logic   job_ready,
   output logic   frame_ack,
   output logic   job_start,
   output pixel_t cur_pixel
);

   logic   busy;
   logic   all_issued;
   logic   last_pixel;
   logic   drain_done;
   coord_t cnt_x;
   coord_t cnt_y;

   assign last_pixel = (cnt_x == coord_t'(WIDTH - 1)) && (cnt_y == coord_t'(HEIGHT - 1));

   // One job per ready cycle while pixels remain in the frame.
   assign job_start = busy && !all_issued && job_ready;

   // The unit is back in ASK_WAIT, so the last write has completed.
   assign drain_done = busy && all_issued && job_ready;

   always_ff @(posedge clk, negedge n_rst) begin
      if (!n_rst) begin
         busy       <= 1'b0;
         all_issued <= 1'b0;
         frame_ack  <= 1'b0;
         cnt_x      <= '0;
         cnt_y      <= '0;
      end else begin
         if (!busy && !frame_ack && frame_req) begin
            busy <= 1'b1;
         end
         if (job_start) begin
            if (last_pixel) begin
               all_issued <= 1'b1;
               cnt_x      <= '0;
               cnt_y      <= '0;
            end else if (cnt_x == coord_t'(WIDTH - 1)) begin
               cnt_x <= '0;
               cnt_y <= cnt_y + 1'b1;
            end else begin
               cnt_x <= cnt_x + 1'b1;
            end
         end
         if (drain_done) begin
            busy       <= 1'b0;
            all_issued <= 1'b0;
            frame_ack  <= 1'b1;
         end
         // Release the frame handshake once the host lets go.
         if (frame_ack && !frame_req) begin
            frame_ack <= 1'b0;
         end
      end
   end

   // Pixel of the job in flight, held until the next job is issued.
   always_ff @(posedge clk) begin
      if (job_start) begin
         cur_pixel.x <= cnt_x;
         cur_pixel.y <= cnt_y;
      end
   end

endmodule

//--- sim.f
hw/fx_math_pkg.sv
hw/job_pkg.sv
hw/work_dispatcher.sv
hw/work_control_unit.sv
hw/coord_converter.sv
hw/escape_calc.sv
hw/result_writer.sv
hw/fractal_top.sv
tb/tb_clock.sv
tb/mem_responder.sv
tb/fractal_tb.sv

//--- tb/fractal_tb.sv
module fractal_tb
   import fx_math_pkg::*, job_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int  WIDTH    = 8;
   localparam int  HEIGHT   = 6;
   localparam int  PIXELS   = WIDTH * HEIGHT;
   localparam int  MAX_ITER = 32;
   localparam fx_t X_MIN    = fx_t'(-8192);
   localparam fx_t Y_MIN    = fx_t'(-5120);
   localparam fx_t STEP     = fx_t'(1792);
   localparam int  FRAMES   = 2;
   localparam int  CLK_NS   = 100;
   localparam int  TIMEOUT_CYCLES = FRAMES * PIXELS * (MAX_ITER + 20);

   logic    clk;
   logic    n_rst;
   logic    frame_req;
   logic    frame_ack;
   logic    mem_req;
   logic    mem_ack;
   mem_wr_t mem_wr;

   iter_t   ref_count [PIXELS];
   int      frames_done;
   int      write_total;
   int      ack_total;
   logic    req_q;
   logic    ack_q;
   logic    saw_max;
   logic    saw_fast;
   mem_wr_t wr_hold;

   tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) clock_i (.clk, .n_rst);

   mem_responder mem_i (.clk, .n_rst, .mem_req, .mem_wr, .mem_ack);

   fractal_top #(
      .WIDTH(WIDTH), .HEIGHT(HEIGHT), .MAX_ITER(MAX_ITER),
      .X_MIN(X_MIN), .Y_MIN(Y_MIN), .STEP(STEP)
   ) dut_i (
      .clk, .n_rst, .frame_req, .mem_ack,
      .frame_ack, .mem_req, .mem_wr
   );

   task automatic fail_run(string what);
      $display("%s", what);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(string test, int expected, int actual);
      fail_run($sformatf("CHECK FAILED %s expected %0d actual %0d",
                         test, expected, actual));
   endtask

   // Escape-time count of one pixel in Q4.12 with a 16-bit wrap on z.
   function automatic iter_t expected_iter(int x, int y);
      fx_t cr;
      fx_t ci;
      fx_t zr;
      fx_t zi;
      int  zr2;
      int  zi2;
      int  zrzi;
      int  n;
      cr = fx_t'(int'(X_MIN) + x * int'(STEP));
      ci = fx_t'(int'(Y_MIN) + y * int'(STEP));
      zr = '0;
      zi = '0;
      n = 0;
      while (n < MAX_ITER) begin
         zr2 = (int'(zr) * int'(zr)) >>> FX_FRAC;
         zi2 = (int'(zi) * int'(zi)) >>> FX_FRAC;
         zrzi = (int'(zr) * int'(zi)) >>> FX_FRAC;
         if (zr2 + zi2 > (4 << FX_FRAC)) begin
            break;
         end
         zi = fx_t'(2 * zrzi + int'(ci));
         zr = fx_t'(zr2 - zi2 + int'(cr));
         n++;
      end
      return iter_t'(n);
   endfunction

   // Host side of the frame handshake.
   task automatic run_frame();
      @(posedge clk);
      #1;
      frame_req = 1'b1;
      do begin
         @(posedge clk);
         #1;
      end while (!frame_ack);
      frame_req = 1'b0;
      frames_done++;
      do begin
         @(posedge clk);
         #1;
      end while (frame_ack);
   endtask

   // Write checks sample on the falling edge.
   always @(negedge clk) begin
      if (!n_rst) begin
         write_total <= 0;
         ack_total   <= 0;
         req_q       <= 1'b0;
         ack_q       <= 1'b0;
         saw_max     <= 1'b0;
         saw_fast    <= 1'b0;
      end else begin
         req_q <= mem_req;
         ack_q <= mem_ack;
         if (mem_req && !req_q) begin
            assert (mem_wr.addr == addr_t'(write_total % PIXELS))
               else report_mismatch("write order", write_total % PIXELS, int'(mem_wr.addr));
            assert (mem_wr.data == ref_count[write_total % PIXELS])
               else report_mismatch($sformatf("write data addr %0d", mem_wr.addr),
                                    int'(ref_count[write_total % PIXELS]), int'(mem_wr.data));
            wr_hold     <= mem_wr;
            write_total <= write_total + 1;
            if (mem_wr.data == iter_t'(MAX_ITER)) begin
               saw_max <= 1'b1;
            end
            if (mem_wr.data == iter_t'(1)) begin
               saw_fast <= 1'b1;
            end
         end else if (mem_req) begin
            assert (mem_wr == wr_hold)
               else report_mismatch("mem_wr stable", int'(wr_hold), int'(mem_wr));
         end
         if (ack_q && !mem_ack) begin
            ack_total <= ack_total + 1;
         end
      end
   end

   reset_outputs_low: assert property (@(posedge clk)
      (!n_rst || $rose(n_rst)) |-> !mem_req && !frame_ack)
      else report_mismatch("reset outputs", 0, int'($sampled({mem_req, frame_ack})));

   req_held_until_ack: assert property (@(posedge clk) disable iff (!n_rst)
      $fell(mem_req) |-> $past(mem_ack))
      else report_mismatch("mem_req fall after mem_ack", 1, 0);

   // Ack as it was on the edge where the request went up.
   req_rises_with_ack_low: assert property (@(posedge clk) disable iff (!n_rst)
      $rose(mem_req) |-> !$past(mem_ack))
      else report_mismatch("mem_req rise with mem_ack low", 0, 1);

   // The host has already counted this frame one cycle after frame_ack rose.
   frame_ack_after_writes: assert property (@(posedge clk) disable iff (!n_rst)
      $rose(frame_ack) |-> ack_total == frames_done * PIXELS)
      else report_mismatch("frame_ack after last write", $sampled(frames_done) * PIXELS,
                           $sampled(ack_total));

   frame_ack_after_req_drop: assert property (@(posedge clk) disable iff (!n_rst)
      $fell(frame_ack) |-> !$past(frame_req))
      else report_mismatch("frame_ack fall after frame_req drop", 0, 1);

   initial begin
      #(TIMEOUT_CYCLES * CLK_NS);
      fail_run($sformatf("Timeout: frames not finished after %0d cycles",
                         TIMEOUT_CYCLES));
   end

   initial begin
      frame_req = 1'b0;
      frames_done = 0;
      for (int y = 0; y < HEIGHT; y++) begin
         for (int x = 0; x < WIDTH; x++) begin
            ref_count[y * WIDTH + x] = expected_iter(x, y);
         end
      end
      @(posedge n_rst);
      repeat (FRAMES) run_frame();
      assert (mem_i.write_log.size() == FRAMES * PIXELS)
         else report_mismatch("write count", FRAMES * PIXELS, mem_i.write_log.size());
      // The second frame must repeat the first one write for write.
      for (int i = 0; i < PIXELS; i++) begin
         assert (mem_i.write_log[i] == mem_i.write_log[i + PIXELS])
            else report_mismatch($sformatf("second frame write %0d", i),
                                 int'(mem_i.write_log[i]), int'(mem_i.write_log[i + PIXELS]));
      end
      assert (saw_max && saw_fast)
         else fail_run(
            "The grid did not produce both a limit count and a first-step escape");
      $display("Test OK");
      $finish;
   end

endmodule

//--- tb/mem_responder.sv
module mem_responder
   import job_pkg::*;
#(
   parameter logic [15:0] SEED = 16'd13
) (
   input  logic    clk,
   input  logic    n_rst,
   input  logic    mem_req,
   input  mem_wr_t mem_wr,
   output logic    mem_ack
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [15:0] lfsr_state;

   // Every request seen, in arrival order.
   mem_wr_t write_log[$];

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   // Two LFSR bits give a delay of 0 to 3 cycles.
   task automatic wait_random_cycles();
      int cycles;
      cycles = 0;
      repeat (2) begin
         cycles = (cycles << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_next(lfsr_state);
      end
      repeat (cycles) begin
         @(posedge clk);
         #1;
      end
   endtask

   initial begin
      mem_ack = 1'b0;
      lfsr_state = SEED;
      forever begin
         @(posedge clk);
         #1;
         if (n_rst && mem_req) begin
            write_log.push_back(mem_wr);
            wait_random_cycles();
            mem_ack = 1'b1;
            while (mem_req) begin
               @(posedge clk);
               #1;
            end
            wait_random_cycles();
            mem_ack = 1'b0;
         end
      end
   end

endmodule

//--- tb/tb_clock.sv
module tb_clock #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic n_rst
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset is released just after a rising edge.
   initial begin
      n_rst = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      n_rst = 1'b1;
   end

endmodule
